// ==== all.f ====
io_pkg.sv
seg_digits.sv
fan_pwm.sv
interval_timer.sv
io_controller.sv
io_controller_sva.sv
tb_io_controller.sv

// ==== fan_pwm.sv ====
`default_nettype none

module fan_pwm (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic [io_pkg::PWM_BITS:0] duty_i,
  output logic                    fan_o
);
  import io_pkg::*;

  logic [PWM_BITS-1:0] cnt_q;
  logic                on_d;

  // one extra bit on the compare so duty 2**PWM_BITS is always on
  assign on_d = ({1'b0, cnt_q} < duty_i);

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      cnt_q <= '0;
      fan_o <= 1'b0;
    end else begin
      cnt_q <= cnt_q + 1'b1;  // wraps freely
      fan_o <= on_d;
    end
  end

endmodule

`default_nettype wire

// ==== interval_timer.sv ====
`default_nettype none

module interval_timer (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          cyc_i,
  input  logic                          stb_i,
  input  logic                          we_i,
  input  logic [3:0]                    adr_i,
  input  logic [31:0]                   dat_i,
  output logic [31:0]                   dat_o,
  output logic                          ack_o,
  output logic [io_pkg::N_TIMER_CH-1:0] interrupt_o
);
  import io_pkg::*;

  logic [31:0]            count_q;
  logic [N_TIMER_CH-1:0]  ctrl_q;    // per channel enable
  logic [N_TIMER_CH-1:0]  status_q;  // sticky
  logic [31:0]            cmp_q [N_TIMER_CH];

  logic                   access;
  logic                   wr_en;
  logic                   is_cmp;
  logic [3:0]             cmp_off;
  logic [CH_IDX_BITS-1:0] cmp_idx;
  logic [N_TIMER_CH-1:0]  hit;
  logic [N_TIMER_CH-1:0]  clr;
  logic [31:0]            rd_word;

  // one access per strobe, ack blocks a repeat on the following edge
  assign access  = cyc_i && stb_i && !ack_o;
  assign wr_en   = access && we_i;
  assign cmp_off = adr_i - TMR_CMP0;
  assign cmp_idx = cmp_off[CH_IDX_BITS-1:0];
  assign is_cmp  = (adr_i >= TMR_CMP0) && (cmp_off < N_TIMER_CH);

  assign interrupt_o = status_q;

  always_comb begin
    for (int i = 0; i < N_TIMER_CH; i++)
      hit[i] = ctrl_q[i] && (count_q == cmp_q[i]);
  end

  assign clr = (wr_en && adr_i == TMR_STATUS) ? dat_i[N_TIMER_CH-1:0] : '0;

  always_comb begin
    rd_word = 32'h0000_0000;  // holes read as zero
    if (is_cmp)
      rd_word = cmp_q[cmp_idx];
    else begin
      case (adr_i)
        TMR_COUNT:  rd_word = count_q;
        TMR_CTRL:   rd_word = 32'(ctrl_q);
        TMR_STATUS: rd_word = 32'(status_q);
        default:    rd_word = 32'h0000_0000;
      endcase
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      count_q  <= 32'h0000_0000;
      ctrl_q   <= '0;
      status_q <= '0;
      ack_o    <= 1'b0;
      for (int i = 0; i < N_TIMER_CH; i++)
        cmp_q[i] <= 32'h0000_0000;
    end else begin
      ack_o    <= access;
      status_q <= (status_q & ~clr) | hit;  // a new hit wins over a clear
      if (wr_en && adr_i == TMR_COUNT)
        count_q <= dat_i;
      else
        count_q <= count_q + 32'd1;
      if (wr_en && adr_i == TMR_CTRL)
        ctrl_q <= dat_i[N_TIMER_CH-1:0];
      if (wr_en && is_cmp)
        cmp_q[cmp_idx] <= dat_i;
    end
  end

  // read data ready together with ack
  always_ff @(posedge clk_i) begin
    if (access && !we_i)
      dat_o <= rd_word;
  end

endmodule

`default_nettype wire

// ==== io_controller.sv ====
`default_nettype none

module io_controller (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          cyc_i,
  input  logic                          stb_i,
  input  logic                          we_i,
  input  logic [16:0]                   adr_i,
  input  logic [31:0]                   dat_i,
  input  logic [3:0]                    sel_i,  // byte selects, full words only
  input  logic [15:0]                   sw_i,
  output logic [31:0]                   dat_o,
  output logic                          ack_o,
  output logic                          fan_o,
  output logic [8:0]                    led_o,
  output logic [io_pkg::N_TIMER_CH-1:0] interrupts_o,
  output logic [6:0]                    hex0_o,
  output logic [6:0]                    hex1_o,
  output logic [6:0]                    hex2_o,
  output logic [6:0]                    hex3_o,
  output logic [6:0]                    hex4_o,
  output logic [6:0]                    hex5_o,
  output logic [6:0]                    hex6_o,
  output logic [6:0]                    hex7_o
);
  import io_pkg::*;

  logic [1:0]  state_q, state_d;
  logic [31:0] seg_q, seg_d;
  logic [31:0] fan_q, fan_d;
  logic [8:0]  led_d;
  logic [31:0] result_d;

  logic [4:0]  selector;
  logic        tmr_cyc;
  logic        tmr_stb;
  logic [31:0] tmr_dat;
  logic        tmr_ack;

  assign selector = adr_i[16:12];
  assign ack_o    = (state_q == ST_DONE);
  assign tmr_cyc  = (state_q == ST_BUSY);
  assign tmr_stb  = (selector == SEL_TIMER);

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
      seg_q   <= SEG_RESET;
      fan_q   <= FAN_RESET;
      led_o   <= 9'h000;
      dat_o   <= 32'h0000_0000;
    end else begin
      state_q <= state_d;
      seg_q   <= seg_d;
      fan_q   <= fan_d;
      led_o   <= led_d;
      dat_o   <= result_d;  // read result holds until next read
    end
  end

  always_comb begin
    state_d  = state_q;
    seg_d    = seg_q;
    fan_d    = fan_q;
    led_d    = led_o;
    result_d = dat_o;
    case (state_q)
      ST_IDLE: begin
        if (cyc_i && stb_i)
          state_d = ST_BUSY;
      end
      ST_BUSY: begin
        case (selector)
          SEL_LOCAL: begin
            if (we_i) begin
              if (adr_i[0] == LOCAL_SEG)
                seg_d = dat_i;
              else
                fan_d = dat_i;
            end else begin
              result_d = (adr_i[0] == LOCAL_FAN) ? fan_q : seg_q;
            end
            state_d = ST_DONE;
          end
          SEL_SWLED: begin
            if (we_i)
              led_d = dat_i[8:0];
            else
              result_d = {16'h0000, sw_i};
            state_d = ST_DONE;
          end
          SEL_TIMER: begin
            // wait for the timer, its read data is already registered
            if (tmr_ack) begin
              if (!we_i)
                result_d = tmr_dat;
              state_d = ST_DONE;
            end
          end
          default: state_d = ST_DONE;  // unmapped, no effect
        endcase
      end
      ST_DONE: state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
  end

  interval_timer interval_timer_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cyc_i       (tmr_cyc),
    .stb_i       (tmr_stb),
    .we_i        (we_i),
    .adr_i       (adr_i[5:2]),
    .dat_i       (dat_i),
    .dat_o       (tmr_dat),
    .ack_o       (tmr_ack),
    .interrupt_o (interrupts_o)
  );

  fan_pwm fan_pwm_i (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .duty_i (fan_q[PWM_BITS:0]),
    .fan_o  (fan_o)
  );

  seg_digits seg_digits_i (
    .value_i (seg_q),
    .hex0_o  (hex0_o),
    .hex1_o  (hex1_o),
    .hex2_o  (hex2_o),
    .hex3_o  (hex3_o),
    .hex4_o  (hex4_o),
    .hex5_o  (hex5_o),
    .hex6_o  (hex6_o),
    .hex7_o  (hex7_o)
  );

endmodule

`default_nettype wire

// ==== io_controller_sva.sv ====
`default_nettype none

module io_controller_sva (
  input logic                          clk_i,
  input logic                          rst_i,
  input logic                          ack_i,
  input logic [1:0]                    state_i,
  input logic [io_pkg::N_TIMER_CH-1:0] interrupts_i
);
  timeunit 1ns;
  timeprecision 100ps;
  import io_pkg::*;

  // one ack pulse per transfer
  ack_single: assert property (
    @(posedge clk_i) disable iff (rst_i) ack_i |=> !ack_i
  ) else $error("ack_o high in two consecutive cycles");

  ack_after_busy: assert property (
    @(posedge clk_i) disable iff (rst_i) ack_i |-> $past(state_i == ST_BUSY)
  ) else $error("ack_o without a busy cycle before it");

  irq_in_reset: assert property (
    @(posedge clk_i) rst_i |-> (interrupts_i == '0)
  ) else $error("interrupts_o not zero during reset");

endmodule

bind io_controller io_controller_sva io_controller_sva_i (
  .clk_i        (clk_i),
  .rst_i        (rst_i),
  .ack_i        (ack_o),
  .state_i      (state_q),
  .interrupts_i (interrupts_o)
);

`default_nettype wire

// ==== io_pkg.sv ====
`default_nettype none

package io_pkg;

  // device selector, taken from adr[16:12]
  localparam logic [4:0] SEL_LOCAL = 5'd0;  // segment + fan registers
  localparam logic [4:0] SEL_SWLED = 5'd1;  // switches in, leds out
  localparam logic [4:0] SEL_TIMER = 5'd8;

  // adr[0] inside SEL_LOCAL
  localparam logic LOCAL_SEG = 1'b0;
  localparam logic LOCAL_FAN = 1'b1;

  // timer word index, adr[5:2]
  localparam logic [3:0] TMR_COUNT  = 4'd0;
  localparam logic [3:0] TMR_CTRL   = 4'd1;
  localparam logic [3:0] TMR_STATUS = 4'd2;
  localparam logic [3:0] TMR_CMP0   = 4'd4;  // compares at 4..7

  localparam int N_TIMER_CH  = 4;
  localparam int CH_IDX_BITS = $clog2(N_TIMER_CH);

  // fan duty is PWM_BITS+1 wide so full on fits
  localparam int PWM_BITS = 8;

  localparam logic [31:0] SEG_RESET = 32'h0000_0000;
  localparam logic [31:0] FAN_RESET = 32'h0000_0000;

  // bus FSM
  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_BUSY = 2'd1;
  localparam logic [1:0] ST_DONE = 2'd2;

endpackage

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# builds and runs the testbench, exit status is the result
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert --top-module tb_io_controller -f all.f -o tb_sim \
  && ./obj_dir/tb_sim \
  || { echo "simulation failed"; exit 1; }

// ==== seg_digits.sv ====
`default_nettype none

module seg_digits (
  input  logic [31:0] value_i,
  output logic [6:0]  hex0_o,
  output logic [6:0]  hex1_o,
  output logic [6:0]  hex2_o,
  output logic [6:0]  hex3_o,
  output logic [6:0]  hex4_o,
  output logic [6:0]  hex5_o,
  output logic [6:0]  hex6_o,
  output logic [6:0]  hex7_o
);

  // hex font, active low, bit 0 is segment a
  function automatic logic [6:0] hex_font(input logic [3:0] nib);
    case (nib)
      4'h0:    hex_font = 7'h40;
      4'h1:    hex_font = 7'h79;
      4'h2:    hex_font = 7'h24;
      4'h3:    hex_font = 7'h30;
      4'h4:    hex_font = 7'h19;
      4'h5:    hex_font = 7'h12;
      4'h6:    hex_font = 7'h02;
      4'h7:    hex_font = 7'h78;
      4'h8:    hex_font = 7'h00;
      4'h9:    hex_font = 7'h10;
      4'ha:    hex_font = 7'h08;
      4'hb:    hex_font = 7'h03;  // lower case b
      4'hc:    hex_font = 7'h46;
      4'hd:    hex_font = 7'h21;  // lower case d
      4'he:    hex_font = 7'h06;
      default: hex_font = 7'h0e;
    endcase
  endfunction

  assign hex0_o = hex_font(value_i[3:0]);  // rightmost digit
  assign hex1_o = hex_font(value_i[7:4]);
  assign hex2_o = hex_font(value_i[11:8]);
  assign hex3_o = hex_font(value_i[15:12]);
  assign hex4_o = hex_font(value_i[19:16]);
  assign hex5_o = hex_font(value_i[23:20]);
  assign hex6_o = hex_font(value_i[27:24]);
  assign hex7_o = hex_font(value_i[31:28]);

endmodule

`default_nettype wire

// ==== tb_io_controller.sv ====
`default_nettype none

module tb_io_controller;
  timeunit 1ns;
  timeprecision 100ps;
  import io_pkg::*;

  logic                  clk_i;
  logic                  rst_i;
  logic                  cyc_i;
  logic                  stb_i;
  logic                  we_i;
  logic [16:0]           adr_i;
  logic [31:0]           dat_i;
  logic [3:0]            sel_i;
  logic [15:0]           sw_i;
  logic [31:0]           dat_o;
  logic                  ack_o;
  logic                  fan_o;
  logic [8:0]            led_o;
  logic [N_TIMER_CH-1:0] interrupts_o;
  logic [6:0]            hex_o [8];

  logic [31:0]           lfsr_q;
  logic [31:0]           shadow_seg;
  logic [31:0]           shadow_fan;
  logic [8:0]            shadow_led;
  logic [15:0]           shadow_sw;
  logic [31:0]           shadow_cmp [N_TIMER_CH];
  logic [N_TIMER_CH-1:0] shadow_ctrl;
  logic [N_TIMER_CH-1:0] shadow_status;
  logic [31:0]           last_result;  // what dat_o should still hold

  io_controller io_controller_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .cyc_i        (cyc_i),
    .stb_i        (stb_i),
    .we_i         (we_i),
    .adr_i        (adr_i),
    .dat_i        (dat_i),
    .sel_i        (sel_i),
    .sw_i         (sw_i),
    .dat_o        (dat_o),
    .ack_o        (ack_o),
    .fan_o        (fan_o),
    .led_o        (led_o),
    .interrupts_o (interrupts_o),
    .hex0_o       (hex_o[0]),
    .hex1_o       (hex_o[1]),
    .hex2_o       (hex_o[2]),
    .hex3_o       (hex_o[3]),
    .hex4_o       (hex_o[4]),
    .hex5_o       (hex_o[5]),
    .hex6_o       (hex_o[6]),
    .hex7_o       (hex_o[7])
  );

  always #4 clk_i = ~clk_i;

  // taps 32,22,2,1, one step per bit
  function automatic logic [31:0] rand_bits(input int nbits);
    logic [31:0] val;
    logic        fb;
    val = 32'h0000_0000;
    for (int i = 0; i < nbits; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic logic [6:0] font_pattern(input logic [3:0] nib);
    logic [6:0] lit [16];  // lit segments, a in bit 0
    lit = '{7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
            7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71};
    return ~lit[nib];  // display is active low
  endfunction

  function automatic logic [6:0] expected_digit(input int d);
    return font_pattern(shadow_seg[4*d +: 4]);
  endfunction

  function automatic logic [31:0] expected_read(input logic [16:0] adr);
    logic [3:0]             idx;
    logic [CH_IDX_BITS-1:0] ch;
    idx = adr[5:2];
    ch  = CH_IDX_BITS'(idx - TMR_CMP0);
    case (adr[16:12])
      SEL_LOCAL: return adr[0] ? shadow_fan : shadow_seg;
      SEL_SWLED: return {16'h0000, shadow_sw};
      SEL_TIMER: begin
        if (idx >= TMR_CMP0 && idx < TMR_CMP0 + 4'(N_TIMER_CH))
          return shadow_cmp[ch];
        else if (idx == TMR_CTRL)
          return 32'(shadow_ctrl);
        else if (idx == TMR_STATUS)
          return 32'(shadow_status);
        else
          return 32'h0000_0000;  // counter is free running
      end
      default: return last_result;  // unmapped keeps the old word
    endcase
  endfunction

  // d high cycles per 256, saturating at full on
  function automatic int expected_fan_highs(input logic [31:0] fan_word);
    logic [PWM_BITS:0] duty;
    duty = fan_word[PWM_BITS:0];
    return (duty > 9'd256) ? 256 : int'(duty);
  endfunction

  task automatic model_write(input logic [16:0] adr, input logic [31:0] data);
    logic [CH_IDX_BITS-1:0] ch;
    ch = CH_IDX_BITS'(adr[5:2] - TMR_CMP0);
    case (adr[16:12])
      SEL_LOCAL: begin
        if (adr[0])
          shadow_fan = data;
        else
          shadow_seg = data;
      end
      SEL_SWLED: shadow_led = data[8:0];
      SEL_TIMER: begin
        if (adr[5:2] == TMR_CTRL)
          shadow_ctrl = data[N_TIMER_CH-1:0];
        else if (adr[5:2] == TMR_STATUS)
          shadow_status = shadow_status & ~data[N_TIMER_CH-1:0];
        else if (adr[5:2] >= TMR_CMP0)
          shadow_cmp[ch] = data;
      end
      default: ;
    endcase
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Mismatch at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
      abort_run("stopping at the first error");
    end
  endtask

  task automatic bus_transfer(input logic we, input logic [16:0] adr, input logic [31:0] data,
                              output logic [31:0] rdata, output int cycles);
    logic done;
    done   = 1'b0;
    cycles = 0;
    @(posedge clk_i);
    cyc_i <= 1'b1;
    stb_i <= 1'b1;
    we_i  <= we;
    adr_i <= adr;
    dat_i <= data;
    sel_i <= 4'hf;
    while (!done) begin
      @(posedge clk_i);
      cycles++;
      @(negedge clk_i);  // ack_o and dat_o settled here
      if (ack_o)
        done = 1'b1;
      else if (cycles >= 50)
        abort_run("bus timeout: ack_o did not arrive within 50 cycles");
    end
    rdata = dat_o;
    @(posedge clk_i);
    cyc_i <= 1'b0;
    stb_i <= 1'b0;
    we_i  <= 1'b0;
  endtask

  task automatic bus_write(input logic [16:0] adr, input logic [31:0] data);
    logic [31:0] unused_rd;
    int          cycles;
    bus_transfer(1'b1, adr, data, unused_rd, cycles);
    model_write(adr, data);
  endtask

  task automatic bus_read(input logic [16:0] adr, output logic [31:0] data, output int cycles);
    bus_transfer(1'b0, adr, 32'h0000_0000, data, cycles);
  endtask

  task automatic read_check(input logic [16:0] adr, input string name, output int cycles);
    logic [31:0] data;
    logic [31:0] expected;
    expected = expected_read(adr);
    bus_read(adr, data, cycles);
    check_value(name, data, expected);
    last_result = expected;
  endtask

  task automatic check_display();
    for (int d = 0; d < 8; d++)
      check_value($sformatf("hex%0d_o", d), 32'(hex_o[d]), 32'(expected_digit(d)));
  endtask

  task automatic fan_duty_test(input logic [31:0] fan_word);
    int highs;
    bus_write({SEL_LOCAL, 11'h000, LOCAL_FAN}, fan_word);
    @(posedge clk_i);  // pwm output is registered
    highs = 0;
    repeat (256) begin
      @(negedge clk_i);
      if (fan_o)
        highs++;
    end
    check_value("fan_o high cycles", 32'(highs), 32'(expected_fan_highs(fan_word)));
  endtask

  task automatic wait_interrupt(input int ch, input int limit);
    int   n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    while (!seen) begin
      @(negedge clk_i);
      n++;
      if (interrupts_o[ch])
        seen = 1'b1;
      else if (n >= limit)
        abort_run("timer interrupt did not rise before the timeout");
    end
  endtask

  function automatic logic [16:0] timer_adr(input logic [3:0] idx);
    return {SEL_TIMER, 6'h00, idx, 2'b00};
  endfunction

  initial begin
    logic [31:0] word;
    logic [31:0] rdata;
    logic [31:0] first_count;
    int          cycles;
    int          ch;
    clk_i  = 1'b0;
    rst_i  = 1'b1;
    cyc_i  = 1'b0;
    stb_i  = 1'b0;
    we_i   = 1'b0;
    adr_i  = 17'h0_0000;
    dat_i  = 32'h0000_0000;
    sel_i  = 4'h0;
    sw_i   = 16'h0000;
    lfsr_q = 32'd98;
    shadow_seg    = SEG_RESET;
    shadow_fan    = FAN_RESET;
    shadow_led    = 9'h000;
    shadow_sw     = 16'h0000;
    shadow_ctrl   = '0;
    shadow_status = '0;
    last_result   = 32'h0000_0000;
    for (int i = 0; i < N_TIMER_CH; i++)
      shadow_cmp[i] = 32'h0000_0000;
    repeat (10) @(posedge clk_i);
    rst_i <= 1'b0;
    @(negedge clk_i);

    // reset values
    check_value("led_o", 32'(led_o), 32'(shadow_led));
    check_value("interrupts_o", 32'(interrupts_o), 32'h0);
    check_value("fan_o", 32'(fan_o), 32'h0);
    check_display();
    read_check({SEL_LOCAL, 11'h000, LOCAL_SEG}, "segment register", cycles);
    check_value("local ack cycle", 32'(cycles), 32'd2);

    repeat (4) begin
      bus_write({SEL_LOCAL, 11'h000, LOCAL_SEG}, rand_bits(32));
      bus_write({SEL_LOCAL, 11'h000, LOCAL_FAN}, rand_bits(32));
      read_check({SEL_LOCAL, 11'h000, LOCAL_SEG}, "segment register", cycles);
      read_check({SEL_LOCAL, 11'h000, LOCAL_FAN}, "fan register", cycles);
      check_display();
    end

    repeat (4) begin
      bus_write({SEL_SWLED, 12'h000}, rand_bits(32));
      @(negedge clk_i);
      check_value("led_o", 32'(led_o), 32'(shadow_led));
      @(posedge clk_i);
      word = rand_bits(16);
      sw_i <= word[15:0];
      shadow_sw = word[15:0];
      read_check({SEL_SWLED, 12'h000}, "switch read", cycles);
    end

    fan_duty_test(32'd0);
    fan_duty_test(32'd256);
    fan_duty_test(rand_bits(8));

    // timer compares, counter, one interrupt channel
    for (int i = 0; i < N_TIMER_CH; i++)
      bus_write(timer_adr(TMR_CMP0 + 4'(i)), rand_bits(32));
    for (int i = 0; i < N_TIMER_CH; i++)
      read_check(timer_adr(TMR_CMP0 + 4'(i)), $sformatf("timer cmp%0d", i), cycles);
    check_value("timer ack cycle", 32'(cycles), 32'd3);
    bus_read(timer_adr(TMR_COUNT), first_count, cycles);
    bus_read(timer_adr(TMR_COUNT), rdata, cycles);
    check_value("counter advanced", 32'(rdata > first_count), 32'd1);
    word = rand_bits(2);
    ch   = int'(word[1:0]);
    word = rand_bits(32);
    bus_write(timer_adr(TMR_COUNT), word);
    bus_write(timer_adr(TMR_CMP0 + 4'(ch)), word + 32'd40);
    bus_write(timer_adr(TMR_CTRL), 32'd1 << ch);
    read_check(timer_adr(TMR_CTRL), "timer ctrl", cycles);
    wait_interrupt(ch, 100);
    shadow_status[ch] = 1'b1;  // enabled compare has matched
    check_value("interrupts_o", 32'(interrupts_o), 32'(shadow_status));
    read_check(timer_adr(TMR_STATUS), "timer status", cycles);
    bus_write(timer_adr(TMR_STATUS), 32'(shadow_status));
    @(negedge clk_i);
    check_value("interrupts_o", 32'(interrupts_o), 32'h0);

    // unmapped selectors
    read_check({SEL_LOCAL, 11'h000, LOCAL_FAN}, "fan register", cycles);
    read_check({5'd3, 12'h000}, "unmapped read", cycles);
    check_value("unmapped ack cycle", 32'(cycles), 32'd2);
    bus_write({5'd3, 12'h001}, rand_bits(32));
    bus_write({5'd20, 12'h000}, rand_bits(32));
    read_check({SEL_LOCAL, 11'h000, LOCAL_SEG}, "segment register", cycles);
    read_check({SEL_LOCAL, 11'h000, LOCAL_FAN}, "fan register", cycles);
    @(negedge clk_i);
    check_value("led_o", 32'(led_o), 32'(shadow_led));
    check_display();

    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire
